/* tests/core_golden.txt */
// columns: instruction word, expected wen, expected rd, expected 64-bit result
// row n sits at pc 4*n; rd and result are only compared when wen is 1
00500093 1 01 0000000000000005 // addi x1,x0,5
ffd00113 1 02 fffffffffffffffd // addi x2,x0,-3
002081b3 1 03 0000000000000002 // add x3,x1,x2
40208233 1 04 0000000000000008 // sub x4,x1,x2
123452b7 1 05 0000000012345000 // lui x5,0x12345
80000337 1 06 ffffffff80000000 // lui x6,0x80000
67828393 1 07 0000000012345678 // addi x7,x5,0x678
0063c433 1 08 ffffffff92345678 // xor x8,x7,x6
007474b3 1 09 0000000012345678 // and x9,x8,x7
0060e533 1 0a ffffffff80000005 // or x10,x1,x6
00708013 0 00 0000000000000000 // addi x0,x1,7
001005b3 1 0b 0000000000000005 // add x11,x0,x1
0000a603 0 0c 0000000000000000 // lw x12,0(x1), unsupported
001606b3 1 0d 0000000000000005 // add x13,x12,x1
00109733 0 0e 0000000000000000 // sll x14,x1,x1, unsupported
4020c7b3 0 0f 0000000000000000 // bad funct3 with funct7 0x20
fff70793 1 0f ffffffffffffffff // addi x15,x14,-1
80078813 1 10 fffffffffffff7ff // addi x16,x15,-2048
7ff00893 1 11 00000000000007ff // addi x17,x0,2047
41088933 1 12 0000000000001000 // sub x18,x17,x16
fffff9b7 1 13 fffffffffffff000 // lui x19,0xfffff
0119ea33 1 14 fffffffffffff7ff // or x20,x19,x17
010a4ab3 1 15 0000000000000000 // xor x21,x20,x16
401a8b33 1 16 fffffffffffffffb // sub x22,x21,x1
016b7033 0 00 0000000000000000 // and x0,x22,x22
01600bb3 1 17 fffffffffffffffb // add x23,x0,x22
017b8c33 1 18 fffffffffffffff6 // add x24,x23,x23
00001037 0 00 0000000000000000 // lui x0,0x1
00ac0c93 1 19 0000000000000000 // addi x25,x24,10
10048f93 1 1f 0000000012345778 // addi x31,x9,0x100
012f8f33 1 1e 0000000012346778 // add x30,x31,x18
41ef0eb3 1 1d 0000000000000000 // sub x29,x30,x30

/* compile.f */
common/rv_pkg.sv
fetch/fetch_unit.sv
design/inst_queue.sv
execute/reg_file.sv
execute/exec_unit.sv
design/core_top.sv
tests/tb_clock.sv
tests/tb_core.sv

/* tests/tb_core.sv */
// run from the project root so the golden file resolves; NUM_ENTRIES must match its row count
`timescale 1ns/100ps
`default_nettype none

module tb_core import rv_pkg::*; ();

  localparam int              NUM_ENTRIES  = 32;
  localparam int              RESET_CYCLES = 16;
  localparam int              CLK_PERIOD   = 4;
  // addi x0,x0,0 returned past the end of the program
  localparam logic [ILEN-1:0] NOP_WORD     = 32'h0000_0013;

  logic            clk;
  logic            i_rst_n;
  logic            i_ibus_ready;
  logic [ILEN-1:0] i_ibus_rdata;
  logic            o_ibus_valid;
  logic [XLEN-1:0] o_ibus_addr;
  logic            o_cmt_valid;
  logic [XLEN-1:0] o_cmt_pc;
  logic            o_cmt_wen;
  reg_idx_t        o_cmt_rd;
  logic [XLEN-1:0] o_cmt_data;

  // four words per entry: instruction, wen, rd, result
  logic [63:0]     golden [0:NUM_ENTRIES*4-1];
  integer          seed;
  int              cmt_count;
  logic [XLEN-1:0] next_addr;
  logic            stalled;
  logic            rst_seen;

  tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk));

  core_top #(.QUEUE_DEPTH(4)) u_dut (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_ibus_ready (i_ibus_ready),
    .i_ibus_rdata (i_ibus_rdata),
    .o_ibus_valid (o_ibus_valid),
    .o_ibus_addr  (o_ibus_addr),
    .o_cmt_valid  (o_cmt_valid),
    .o_cmt_pc     (o_cmt_pc),
    .o_cmt_wen    (o_cmt_wen),
    .o_cmt_rd     (o_cmt_rd),
    .o_cmt_data   (o_cmt_data)
  );

  //////////////////////////////
  // memory model

  function automatic logic [ILEN-1:0] word_at(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] idx;
    idx = addr >> 2;
    if (idx < NUM_ENTRIES) begin
      return golden[idx*4][ILEN-1:0];
    end else begin
      return NOP_WORD;
    end
  endfunction

  assign i_ibus_rdata = word_at(o_ibus_addr);

  // ready high on about three cycles in four
  always @(posedge clk) begin
    i_ibus_ready <= (($random(seed) & 3) != 0);
  end

  //////////////////////////////
  // checking

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_commit(input int idx);
    logic        exp_wen;
    logic [63:0] exp_pc;
    exp_wen = golden[idx*4+1][0];
    exp_pc  = idx * 4;
    check_value($sformatf("entry %0d pc", idx), exp_pc, o_cmt_pc);
    check_value($sformatf("entry %0d wen", idx), {63'd0, exp_wen}, {63'd0, o_cmt_wen});
    // rd and data only mean something when the register is written
    if (exp_wen) begin
      check_value($sformatf("entry %0d rd", idx), golden[idx*4+2], {59'd0, o_cmt_rd});
      check_value($sformatf("entry %0d data", idx), golden[idx*4+3], o_cmt_data);
    end
  endtask

  // sampled on the falling edge, half a cycle away from any change
  // starts after the first rising edge, which applies reset
  initial begin
    @(posedge clk);
    forever begin
      @(negedge clk);
      if (!rst_seen) begin
        check_value("reset ibus valid", 64'd0, {63'd0, o_ibus_valid});
        check_value("reset commit valid", 64'd0, {63'd0, o_cmt_valid});
      end else begin
        if (o_ibus_valid === 1'b1) begin
          check_value(stalled ? "stalled fetch addr" : "fetch addr", next_addr, o_ibus_addr);
          if (i_ibus_ready) begin
            next_addr = next_addr + 64'd4;
          end
        end
        stalled = (o_ibus_valid === 1'b1) && !i_ibus_ready;
        if (o_cmt_valid === 1'b1 && cmt_count < NUM_ENTRIES) begin
          check_commit(cmt_count);
          cmt_count = cmt_count + 1;
        end
      end
      rst_seen = i_rst_n;
    end
  end

  //////////////////////////////
  // main sequence and watchdog

  initial begin
    seed         = 32'hfd8f_a459;
    i_rst_n      = 1'b0;
    i_ibus_ready = 1'b0;
    cmt_count    = 0;
    next_addr    = RESET_PC;
    stalled      = 1'b0;
    rst_seen     = 1'b0;
    $readmemh("tests/core_golden.txt", golden);
    if (^golden[NUM_ENTRIES*4-1] === 1'bx) begin
      $display("Error: golden file is missing or has fewer than %0d entries", NUM_ENTRIES);
      $display("*** FAILED ***");
      $fatal(1, "golden file load");
    end
    repeat (RESET_CYCLES) @(posedge clk);
    i_rst_n <= 1'b1;
    wait (cmt_count == NUM_ENTRIES);
    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    repeat (RESET_CYCLES + 20 * NUM_ENTRIES) @(posedge clk);
    $display("Error: commits stopped arriving, %0d of %0d entries seen", cmt_count,
             NUM_ENTRIES);
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
// free-running clock that starts low; PERIOD is in ns and must be even
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* design/core_top.sv */
// core top; the instruction bus is the only memory port and commits come out in fetch order
`timescale 1ns/100ps
`default_nettype none

module core_top import rv_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire logic            clk,
  input  wire logic            i_rst_n,
  // instruction bus
  input  wire logic            i_ibus_ready,
  input  wire logic [ILEN-1:0] i_ibus_rdata,
  output      logic            o_ibus_valid,
  output      logic [XLEN-1:0] o_ibus_addr,
  // commit port
  output      logic            o_cmt_valid,
  output      logic [XLEN-1:0] o_cmt_pc,
  output      logic            o_cmt_wen,
  output      reg_idx_t        o_cmt_rd,
  output      logic [XLEN-1:0] o_cmt_data
);

  //////////////////////////////
  // fetch to queue
  logic            q_ready;
  logic            q_push;
  logic [XLEN-1:0] q_pc;
  logic [ILEN-1:0] q_inst;

  // queue to execute
  logic            ex_valid;
  logic [XLEN-1:0] ex_pc;
  logic [ILEN-1:0] ex_inst;
  logic            ex_pop;

  fetch_unit u_fetch (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_ibus_ready (i_ibus_ready),
    .i_ibus_rdata (i_ibus_rdata),
    .o_ibus_valid (o_ibus_valid),
    .o_ibus_addr  (o_ibus_addr),
    .i_q_ready    (q_ready),
    .o_q_push     (q_push),
    .o_q_pc       (q_pc),
    .o_q_inst     (q_inst)
  );

  inst_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .PC_W        (XLEN),
    .INST_W      (ILEN)
  ) u_queue (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_push  (q_push),
    .i_pc    (q_pc),
    .i_inst  (q_inst),
    .o_ready (q_ready),
    .o_valid (ex_valid),
    .o_pc    (ex_pc),
    .o_inst  (ex_inst),
    .i_pop   (ex_pop)
  );

  exec_unit u_exec (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (ex_valid),
    .i_pc        (ex_pc),
    .i_inst      (ex_inst),
    .o_pop       (ex_pop),
    .o_cmt_valid (o_cmt_valid),
    .o_cmt_pc    (o_cmt_pc),
    .o_cmt_wen   (o_cmt_wen),
    .o_cmt_rd    (o_cmt_rd),
    .o_cmt_data  (o_cmt_data)
  );

endmodule

`default_nettype wire

/* execute/exec_unit.sv */
// single-cycle execute for add/sub/and/or/xor/addi/lui; other encodings commit without a write
`timescale 1ns/100ps
`default_nettype none

module exec_unit import rv_pkg::*; (
  input  wire logic            clk,
  input  wire logic            i_rst_n,
  // from the queue
  input  wire logic            i_valid,
  input  wire logic [XLEN-1:0] i_pc,
  input  wire logic [ILEN-1:0] i_inst,
  output      logic            o_pop,
  // commit port
  output      logic            o_cmt_valid,
  output      logic [XLEN-1:0] o_cmt_pc,
  output      logic            o_cmt_wen,
  output      reg_idx_t        o_cmt_rd,
  output      logic [XLEN-1:0] o_cmt_data
);

  opcode_e         op;
  reg_idx_t        rs1;
  reg_idx_t        rs2;
  reg_idx_t        rd;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] result;
  logic            rd_wen;

  // always ready
  assign o_pop = i_valid;

  //////////////////////////////
  // decode

  assign rs1    = i_inst[19:15];
  assign rs2    = i_inst[24:20];
  assign rd     = i_inst[11:7];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign imm_i  = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u  = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};

  always_comb begin
    op = OP_NONE;
    case (i_inst[6:0])
      OPC_REG: begin
        if (funct7 == F7_BASE) begin
          case (funct3)
            3'b000:  op = OP_ADD;
            3'b100:  op = OP_XOR;
            3'b110:  op = OP_OR;
            3'b111:  op = OP_AND;
            default: op = OP_NONE;
          endcase
        end else if (funct7 == F7_ALT && funct3 == 3'b000) begin
          op = OP_SUB;
        end
      end
      OPC_IMM: begin
        if (funct3 == 3'b000) begin
          op = OP_ADDI;
        end
      end
      OPC_LUI: op = OP_LUI;
      default: op = OP_NONE;
    endcase
  end

  reg_file u_reg_file (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_rd       (rd),
    .i_rd_wen   (o_pop && rd_wen),
    .i_rd_data  (result)
  );

  //////////////////////////////
  // arithmetic

  always_comb begin
    result = '0;
    case (op)
      OP_ADD:  result = rs1_data + rs2_data;
      OP_SUB:  result = rs1_data - rs2_data;
      OP_AND:  result = rs1_data & rs2_data;
      OP_OR:   result = rs1_data | rs2_data;
      OP_XOR:  result = rs1_data ^ rs2_data;
      OP_ADDI: result = rs1_data + imm_i;
      OP_LUI:  result = imm_u;
      default: result = '0;
    endcase
  end

  // x0 target or unknown op leaves the file alone
  assign rd_wen = (op != OP_NONE) && (rd != '0);

  //////////////////////////////
  // commit, same edge as the register write

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_cmt_valid <= 1'b0;
      o_cmt_wen   <= 1'b0;
    end else begin
      o_cmt_valid <= o_pop;
      o_cmt_wen   <= o_pop && rd_wen;
    end
  end

  always_ff @(posedge clk) begin
    if (o_pop) begin
      o_cmt_pc   <= i_pc;
      o_cmt_rd   <= rd;
      o_cmt_data <= result;
    end
  end

endmodule

`default_nettype wire

/* execute/reg_file.sv */
// 31 general registers plus hardwired x0; reads are combinational and see pre-write data
`timescale 1ns/100ps
`default_nettype none

module reg_file import rv_pkg::*; (
  input  wire logic            clk,
  input  wire logic            i_rst_n,
  input  wire reg_idx_t        i_rs1,
  input  wire reg_idx_t        i_rs2,
  output      logic [XLEN-1:0] o_rs1_data,
  output      logic [XLEN-1:0] o_rs2_data,
  input  wire reg_idx_t        i_rd,
  input  wire logic            i_rd_wen,
  input  wire logic [XLEN-1:0] i_rd_data
);

  // no storage behind x0
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

/* design/inst_queue.sv */
// in-order fifo of pc/instruction pairs; QUEUE_DEPTH must be a power of two, 2 or more
`timescale 1ns/100ps
`default_nettype none

module inst_queue import rv_pkg::*; #(
  parameter int QUEUE_DEPTH = 4,
  parameter int PC_W        = XLEN,
  parameter int INST_W      = ILEN
) (
  input  wire logic              clk,
  input  wire logic              i_rst_n,
  // write side
  input  wire logic              i_push,
  input  wire logic [PC_W-1:0]   i_pc,
  input  wire logic [INST_W-1:0] i_inst,
  output      logic              o_ready,
  // read side
  output      logic              o_valid,
  output      logic [PC_W-1:0]   o_pc,
  output      logic [INST_W-1:0] o_inst,
  input  wire logic              i_pop
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  logic [PC_W-1:0]   pc_mem   [QUEUE_DEPTH];
  logic [INST_W-1:0] inst_mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;
  logic              do_push;
  logic              do_pop;

  assign o_ready = (count != QUEUE_DEPTH[PTR_W:0]);
  assign o_valid = (count != '0);
  assign do_push = i_push && o_ready;
  assign do_pop  = i_pop && o_valid;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap on their own with a power-of-two depth
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      pc_mem[wr_ptr]   <= i_pc;
      inst_mem[wr_ptr] <= i_inst;
    end
  end

  assign o_pc   = pc_mem[rd_ptr];
  assign o_inst = inst_mem[rd_ptr];

endmodule

`default_nettype wire

/* fetch/fetch_unit.sv */
// sequential fetch only, pc steps by 4 per transfer; requests only while the queue is not full
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import rv_pkg::*; (
  input  wire logic               clk,
  input  wire logic               i_rst_n,
  // instruction bus
  input  wire logic               i_ibus_ready,
  input  wire logic [ILEN-1:0]    i_ibus_rdata,
  output      logic               o_ibus_valid,
  output      logic [XLEN-1:0]    o_ibus_addr,
  // push side of the queue
  input  wire logic               i_q_ready,
  output      logic               o_q_push,
  output      logic [XLEN-1:0]    o_q_pc,
  output      logic [ILEN-1:0]    o_q_inst
);

  logic            run_q;
  logic [XLEN-1:0] pc_q;
  logic            hold_valid;
  logic [XLEN-1:0] hold_pc;
  logic [ILEN-1:0] hold_inst;
  logic            xfer;

  // a transfer only happens with queue room, so the holding
  // register is always free or draining in that cycle
  assign o_ibus_valid = run_q && i_q_ready;
  assign o_ibus_addr  = pc_q;
  assign xfer         = o_ibus_valid && i_ibus_ready;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      run_q      <= 1'b0;
      pc_q       <= RESET_PC;
      hold_valid <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (xfer) begin
        pc_q <= pc_q + 64'd4;
      end
      if (xfer) begin
        hold_valid <= 1'b1;
      end else if (hold_valid && i_q_ready) begin
        hold_valid <= 1'b0;
      end
    end
  end

  // word and its pc, pushed the cycle after the transfer
  always_ff @(posedge clk) begin
    if (xfer) begin
      hold_pc   <= pc_q;
      hold_inst <= i_ibus_rdata;
    end
  end

  assign o_q_push = hold_valid;
  assign o_q_pc   = hold_pc;
  assign o_q_inst = hold_inst;

endmodule

`default_nettype wire

/* common/rv_pkg.sv */
// shared widths and encodings for the rv64 subset core; RESET_PC must be word aligned
`default_nettype none

package rv_pkg;

  // data and instruction widths
  localparam int XLEN = 64;
  localparam int ILEN = 32;

  // first fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 64'h0;

  typedef logic [4:0] reg_idx_t;

  // major opcodes, bits 6:0 of the instruction word
  localparam logic [6:0] OPC_REG = 7'b0110011;
  localparam logic [6:0] OPC_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI = 7'b0110111;

  // funct7 values for the register-register group
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // decoded operation
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_LUI,
    OP_NONE
  } opcode_e;

endpackage

`default_nettype wire
